/* bus_accept.sv */
`timescale 1ns/100ps
`include "irq_settings.svh"

// system bus interrupt acceptor, rin/dok handshake
module bus_accept (
	input logic clk,
	input logic reset,
	input logic rin,
	input irq_pkg::word_t rdt,
	output logic dok,
	irq_set_if.src set_port
);

	localparam int cnt_w = $clog2(`DOK_DLY_TICKS + 1);

	irq_pkg::acc_state_t state;
	logic [cnt_w-1:0] cnt; // clocks left in acc_wait
	irq_pkg::kind_t kind;
	irq_pkg::chan_t chan_num;

	// rin seen at edge n, acc_ack covers the clock before edge n+DOK_DLY_TICKS
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= irq_pkg::acc_idle;
			cnt <= '0;
			dok <= 1'b0;
		end else begin
			dok <= (state == irq_pkg::acc_ack); // one clock after the set
			case (state)
				irq_pkg::acc_idle: begin
					if (rin) begin
						state <= irq_pkg::acc_wait;
						cnt <= cnt_w'(`DOK_DLY_TICKS - 2);
					end
				end
				irq_pkg::acc_wait: begin
					if (cnt == '0)
						state <= irq_pkg::acc_ack;
					else
						cnt <= cnt - 1'b1;
				end
				irq_pkg::acc_ack: state <= irq_pkg::acc_release;
				irq_pkg::acc_release: begin
					if (!rin)
						state <= irq_pkg::acc_idle; // requester let go
				end
				default: state <= irq_pkg::acc_idle;
			endcase
		end
	end

	// rdt bit 15 selects cpu request vs channel
	always_comb begin
		if (!rdt[15])
			kind = irq_pkg::kind_chan;
		else if (rdt[0])
			kind = irq_pkg::kind_cpu_lo;
		else
			kind = irq_pkg::kind_cpu_hi;
	end

	assign chan_num = rdt[11:14];

	assign set_port.set_valid = (state == irq_pkg::acc_ack);
	assign set_port.set_kind = kind;
	assign set_port.set_chan_num = chan_num;

	// channel decoder, only enabled during the set
	always_comb begin
		set_port.set_chan = '0;
		if (set_port.set_valid && (kind == irq_pkg::kind_chan))
			set_port.set_chan[chan_num] = 1'b1;
	end

	a_dok_pulse: assert property (@(posedge clk) disable iff (reset)
		dok |=> !dok)
		else $error("dok high for two cycles");

endmodule

/* irq_ctrl.sv */
`timescale 1ns/100ps

// interrupt system top, RM + RZ + RP + bus acceptor
module irq_ctrl (
	input logic clk,
	input logic reset,
	input irq_pkg::hw_lines_t hw_irq,
	input irq_pkg::word_t data,
	input logic mask_wr,
	input logic rz_wr,
	input logic accept,
	input logic rtn,
	input logic rin,
	input irq_pkg::word_t rdt,
	output logic dok,
	output logic irq,
	output irq_pkg::level_t vec,
	output logic vec_valid,
	output irq_pkg::word_t rz_user
);

	irq_pkg::mask_t rm;

	irq_set_if set_bus ();
	irq_pend_if pend_bus ();

	mask_reg reg_rm (
		.clk(clk),
		.reset(reset),
		.mask_wr(mask_wr),
		.data(data),
		.rm(rm)
	);

	req_reg reg_rz (
		.clk(clk),
		.reset(reset),
		.hw_irq(hw_irq),
		.rz_wr(rz_wr),
		.data(data),
		.rm(rm),
		.set_port(set_bus.dst),
		.pend_port(pend_bus.req),
		.rz_user(rz_user)
	);

	serv_chain reg_rp (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.rtn(rtn),
		.pend_port(pend_bus.srv),
		.irq(irq),
		.vec(vec),
		.vec_valid(vec_valid)
	);

	bus_accept acc_bus (
		.clk(clk),
		.reset(reset),
		.rin(rin),
		.rdt(rdt),
		.dok(dok),
		.set_port(set_bus.src)
	);

endmodule

/* irq_pend_if.sv */
`timescale 1ns/100ps

// RZ side and RP side of the interrupt system
interface irq_pend_if;

	irq_pkg::irq_vec_t pending; // masked RZ
	irq_pkg::irq_vec_t block; // levels held off by the priority chain
	logic accept_fire; // one cycle, clears the RZ bit
	irq_pkg::level_t accept_level; // level being taken

	// request register
	modport req (
		output pending,
		input block,
		input accept_fire,
		input accept_level
	);

	// service chain
	modport srv (
		input pending,
		output block,
		output accept_fire,
		output accept_level
	);

endinterface

/* irq_pkg.sv */
`include "irq_settings.svh"

package irq_pkg;

	// bit 0 is the msb, same numbering as the bus and the W word
	typedef logic [0:15] word_t;

	// one bit per level, index equals level number
	// level 0 has the highest priority
	typedef logic [0:`IRQ_LEVELS-1] irq_vec_t;

	typedef logic [0:`MASK_BITS-1] mask_t; // RM contents
	typedef logic [$clog2(`IRQ_LEVELS)-1:0] level_t; // accepted level number
	typedef logic [$clog2(`CHAN_COUNT)-1:0] chan_t; // bus channel number

	// levels 0..10 in bits 0..10, operator request (28) in bit 11
	typedef logic [0:11] hw_lines_t;

	// what a bus request asks for
	typedef logic [1:0] kind_t;
	localparam kind_t kind_chan = 2'd0; // channel, levels 12..27
	localparam kind_t kind_cpu_hi = 2'd1; // other CPU high, level 3
	localparam kind_t kind_cpu_lo = 2'd2; // other CPU low, level 29

	// bus acceptor FSM
	typedef enum logic [1:0] {
		acc_idle,
		acc_wait,
		acc_ack,
		acc_release
	} acc_state_t;

endpackage

/* irq_set_if.sv */
`timescale 1ns/100ps
`include "irq_settings.svh"

// bus acceptor to RZ, set happens in the cycle set_valid is high
interface irq_set_if;

	logic set_valid; // one cycle, no handshake back
	logic [0:`CHAN_COUNT-1] set_chan; // decoded channel, one hot or zero
	irq_pkg::kind_t set_kind; // channel / cpu high / cpu low
	irq_pkg::chan_t set_chan_num; // channel number straight from rdt

	modport src (
		output set_valid,
		output set_chan,
		output set_kind,
		output set_chan_num
	);

	modport dst (
		input set_valid,
		input set_chan,
		input set_kind,
		input set_chan_num
	);

endinterface

/* irq_settings.svh */
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// one RZ bit per level, level 0 on top
`define IRQ_LEVELS 32

// channels addressable over the system bus
`define CHAN_COUNT 16

`define MASK_BITS 10 // RM width, one bit per level group

// clocks from rin seen to RZ set, dok follows one clock later
// must be 2 or more
`define DOK_DLY_TICKS 4

`endif

/* mask_reg.sv */
`timescale 1ns/100ps
`include "irq_settings.svh"

// RM, interrupt mask register
module mask_reg (
	input logic clk,
	input logic reset,
	input logic mask_wr,
	input irq_pkg::word_t data,
	output irq_pkg::mask_t rm
);

	// top bits of the word hold the mask
	always_ff @(posedge clk) begin
		if (reset) begin
			rm <= '0; // everything but level 0 masked
		end else if (mask_wr) begin
			rm <= data[0:`MASK_BITS-1];
		end
	end

	// a write in the same cycle as reset must not survive
	a_rm_reset: assert property (@(posedge clk) reset |=> (rm == '0))
		else $error("rm not cleared by reset");

endmodule

/* req_reg.sv */
`timescale 1ns/100ps
`include "irq_settings.svh"

// RZ, interrupt request register
module req_reg (
	input logic clk,
	input logic reset,
	input irq_pkg::hw_lines_t hw_irq,
	input logic rz_wr,
	input irq_pkg::word_t data,
	input irq_pkg::mask_t rm,
	irq_set_if.dst set_port,
	irq_pend_if.req pend_port,
	output irq_pkg::word_t rz_user
);

	irq_pkg::irq_vec_t rz; // request bits
	irq_pkg::irq_vec_t imask; // rm spread over the levels
	irq_pkg::irq_vec_t hw_set; // hardware lines at their levels
	irq_pkg::irq_vec_t bus_set; // bus request at its level
	irq_pkg::irq_vec_t rz_next;

	// each mask bit gates a fixed group of levels
	assign imask = {
		1'b1, // 0, power out
		rm[0:3], // 1..4 one bit each
		{7{rm[4]}}, // 5..11
		{2{rm[5]}}, // 12..13
		{2{rm[6]}}, // 14..15
		{6{rm[7]}}, // 16..21
		{6{rm[8]}}, // 22..27
		{4{rm[9]}} // 28..31
	};

	assign hw_set = {
		hw_irq[0:10], // 0..10
		17'b0, // 11 unused, channels have no hw line
		hw_irq[11], // 28 operator request
		3'b0 // 29..31 from bus or software only
	};

	always_comb begin
		bus_set = '0;
		if (set_port.set_valid) begin
			bus_set[3] = (set_port.set_kind == irq_pkg::kind_cpu_hi);
			bus_set[29] = (set_port.set_kind == irq_pkg::kind_cpu_lo);
			bus_set[12 +: `CHAN_COUNT] = set_port.set_chan; // zero unless channel
		end
	end

	// write first, then clear on accept, sets last
	// so a line still held high keeps its bit
	always_comb begin
		rz_next = rz;
		if (rz_wr) begin
			rz_next[0:11] = data[0:11];
			rz_next[28:31] = data[12:15]; // channel levels untouched
		end
		if (pend_port.accept_fire) begin
			rz_next[pend_port.accept_level] = 1'b0;
		end
		rz_next = rz_next | hw_set | bus_set;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rz <= '0;
		end else begin
			rz <= rz_next;
		end
	end

	assign pend_port.pending = rz & imask;

	// channel levels are not visible to software
	assign rz_user = {rz[0:11], rz[28:31]};

	// service chain may only take a level that is pending and unblocked
	a_fire_pending: assert property (@(posedge clk) disable iff (reset)
		pend_port.accept_fire |->
			(pend_port.pending[pend_port.accept_level] &&
			!pend_port.block[pend_port.accept_level]))
		else $error("accept of level %0d not pending", pend_port.accept_level);

	// decoded channel must agree with the channel number
	a_chan_decode: assert property (@(posedge clk) disable iff (reset)
		(set_port.set_valid && (set_port.set_kind == irq_pkg::kind_chan)) |->
			($onehot(set_port.set_chan) && set_port.set_chan[set_port.set_chan_num]))
		else $error("bus channel decode mismatch");

endmodule

/* serv_chain.sv */
`timescale 1ns/100ps
`include "irq_settings.svh"

// RP, priority chain and vector output
module serv_chain (
	input logic clk,
	input logic reset,
	input logic accept,
	input logic rtn,
	irq_pend_if.srv pend_port,
	output logic irq,
	output irq_pkg::level_t vec,
	output logic vec_valid
);

	irq_pkg::irq_vec_t rp; // levels in service
	irq_pkg::irq_vec_t block;
	irq_pkg::irq_vec_t eligible; // pending and not held off
	irq_pkg::level_t sel_level; // best eligible level
	irq_pkg::level_t top_level; // highest level in service

	// lowest set index, zero for an empty vector
	function automatic irq_pkg::level_t first_set(input irq_pkg::irq_vec_t v);
		irq_pkg::level_t lvl;
		lvl = '0;
		for (int i = `IRQ_LEVELS-1; i >= 0; i--) begin
			if (v[i])
				lvl = irq_pkg::level_t'(i);
		end
		return lvl;
	endfunction

	// chain runs from level 0 down, service at any level
	// holds off itself and everything below
	always_comb begin
		block[0] = rp[0];
		for (int i = 1; i < `IRQ_LEVELS; i++) begin
			block[i] = block[i-1] | rp[i];
		end
	end

	assign eligible = pend_port.pending & ~block;
	assign irq = |eligible;

	assign sel_level = first_set(eligible);
	assign top_level = first_set(rp);

	assign pend_port.block = block;
	assign pend_port.accept_fire = accept & irq; // accept without irq ignored
	assign pend_port.accept_level = sel_level;

	// accepted level is always above everything in service,
	// so rtn and accept never hit the same bit
	always_ff @(posedge clk) begin
		if (reset) begin
			rp <= '0;
		end else begin
			if (rtn)
				rp[top_level] <= 1'b0;
			if (pend_port.accept_fire)
				rp[sel_level] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vec_valid <= 1'b0;
		end else begin
			vec_valid <= pend_port.accept_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (pend_port.accept_fire)
			vec <= sel_level; // held until next accept
	end

	// a level just taken is blocked, so no back to back accepts
	a_vec_pulse: assert property (@(posedge clk) disable iff (reset)
		vec_valid |=> !vec_valid)
		else $error("vec_valid longer than one cycle");

	a_rtn_empty: assert property (@(posedge clk) disable iff (reset)
		rtn |-> (|rp))
		else $error("rtn with no level in service");

endmodule

/* sim.f */
+incdir+.
irq_pkg.sv
irq_set_if.sv
irq_pend_if.sv
mask_reg.sv
req_reg.sv
serv_chain.sv
bus_accept.sv
irq_ctrl.sv
tb_irq_ctrl.sv

/* tb_irq_checks.svh */
`ifndef TB_IRQ_CHECKS_SVH
`define TB_IRQ_CHECKS_SVH

int n_checks = 0;
int n_errors = 0;
logic [15:0] lfsr = 16'd44; // seed
irq_pkg::irq_vec_t m_rz = '0; // model of RZ
irq_pkg::irq_vec_t m_rp = '0; // model of RP
irq_pkg::mask_t m_rm = '0; // model of RM

// galois form, taps 16 14 13 11, one shift per bit taken
function automatic int rand_bits(input int n);
	int r;
	r = 0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		r = (r << 1) | int'(lfsr[0]);
	end
	return r;
endfunction

// group table of the mask register
function automatic logic level_on(input int lv);
	if (lv == 0) return 1'b1; // power out, never masked
	else if (lv <= 4) return m_rm[lv-1];
	else if (lv <= 11) return m_rm[4];
	else if (lv <= 13) return m_rm[5];
	else if (lv <= 15) return m_rm[6];
	else if (lv <= 21) return m_rm[7];
	else if (lv <= 27) return m_rm[8];
	return m_rm[9]; // 28..31
endfunction

// highest level in service, IRQ_LEVELS when RP is empty
function automatic int top_in_service();
	for (int i = 0; i < `IRQ_LEVELS; i++)
		if (m_rp[i]) return i;
	return `IRQ_LEVELS;
endfunction

// level the next accept should take, -1 for none
function automatic int best_level();
	int top;
	top = top_in_service();
	for (int i = 0; i < top; i++)
		if (m_rz[i] && level_on(i)) return i;
	return -1;
endfunction

function automatic irq_pkg::word_t user_view();
	irq_pkg::word_t w;
	w[0:11] = m_rz[0:11];
	w[12:15] = m_rz[28:31]; // channel levels hidden
	return w;
endfunction

// rdt bit 15 picks cpu request, bit 0 picks low or high
function automatic int bus_level(input irq_pkg::word_t w);
	if (!w[15]) return 12 + int'(w[11:14]);
	else if (w[0]) return 29;
	return 3;
endfunction

task automatic check_bit(input string name, input logic got, input logic exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_level(input string name, input irq_pkg::level_t got,
		input irq_pkg::level_t exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_word(input string name, input irq_pkg::word_t got,
		input irq_pkg::word_t exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

`endif

/* tb_irq_ctrl.sv */
`timescale 1ns/100ps
`include "irq_settings.svh"

module tb_irq_ctrl;

	typedef enum {op_hw, op_mask, op_rzwrite, op_accept, op_rtn, op_bus} op_t;
	typedef struct {
		op_t op;
		bit rnd; // operand drawn from the lfsr
		irq_pkg::word_t arg;
		int exp; // accepted level, -1 for none
	} step_t;

	logic clk, reset, mask_wr, rz_wr, accept, rtn, rin;
	irq_pkg::hw_lines_t hw_irq;
	irq_pkg::word_t data, rdt, rz_user;
	logic dok, irq, vec_valid;
	irq_pkg::level_t vec;
	step_t tbl[$];
	bit table_ready = 1'b0;

	`include "tb_irq_checks.svh"

	irq_ctrl DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns
	end

	task automatic tick();
		@(posedge clk);
		#5; // drive and sample point
	endtask

	task automatic add_step(input op_t op, input irq_pkg::word_t arg = '0,
			input int exp = -1, input bit rnd = 1'b0);
		step_t s;
		s.op = op;
		s.rnd = rnd;
		s.arg = arg;
		s.exp = exp;
		tbl.push_back(s);
	endtask

	task automatic build_table();
		add_step(op_mask, 16'hFFC0); // all groups open
		add_step(op_hw, 16'h0100); // level 7
		add_step(op_accept, '0, 7);
		add_step(op_rtn);
		add_step(op_accept, '0, -1); // RZ bit gone
		add_step(op_hw, 16'h2440); // levels 2, 5, 9
		add_step(op_accept, '0, 2);
		add_step(op_accept, '0, -1); // 5 and 9 held off by 2
		add_step(op_rtn);
		add_step(op_accept, '0, 5);
		add_step(op_rtn);
		add_step(op_accept, '0, 9);
		add_step(op_hw, 16'h4000); // level 1 nests above 9
		add_step(op_accept, '0, 1);
		add_step(op_rtn);
		add_step(op_rtn);
		add_step(op_mask, 16'h0000);
		add_step(op_hw, 16'h8000); // level 0 ignores the mask
		add_step(op_rzwrite, 16'h0000);
		for (int i = 0; i < 8; i++) begin
			add_step(op_mask, '0, -1, 1'b1);
			add_step(op_hw, '0, -1, 1'b1); // one random line
			add_step(op_rzwrite, 16'h0000);
		end
		add_step(op_mask, 16'hFFC0);
		add_step(op_bus, 16'h000A); // channel 5, level 17
		add_step(op_rzwrite, 16'hA5C3);
		add_step(op_rzwrite, 16'h0000); // channel bit must survive
		add_step(op_accept, '0, 17);
		add_step(op_rtn);
		add_step(op_bus, 16'h0001); // cpu high
		add_step(op_bus, 16'h8001); // cpu low
		add_step(op_bus, 16'h001E); // channel 15
		add_step(op_accept, '0, 3);
		add_step(op_rtn);
		add_step(op_accept, '0, 27);
		add_step(op_rtn);
		add_step(op_accept, '0, 29);
		add_step(op_rtn);
	endtask

	task automatic run_step(input int idx, input step_t s);
		irq_pkg::word_t arg;
		int lv;
		int n;
		arg = s.arg;
		case (s.op)
			op_hw: begin
				if (s.rnd) begin
					arg = '0;
					arg[rand_bits(4) % 12] = 1'b1;
				end
				hw_irq = arg[0:11];
				for (int b = 0; b < 11; b++)
					if (arg[b]) m_rz[b] = 1'b1;
				if (arg[11]) m_rz[28] = 1'b1; // operator line
				tick();
				hw_irq = '0;
			end
			op_mask: begin
				if (s.rnd) begin
					arg = '0;
					arg[0:9] = 10'(rand_bits(10));
				end
				data = arg;
				mask_wr = 1'b1;
				m_rm = arg[0:9];
				tick();
				mask_wr = 1'b0;
			end
			op_rzwrite: begin
				data = arg;
				rz_wr = 1'b1;
				m_rz[0:11] = arg[0:11];
				m_rz[28:31] = arg[12:15];
				tick();
				rz_wr = 1'b0;
			end
			op_accept: begin
				lv = best_level();
				if (lv != s.exp) begin
					n_errors++;
					$display("Error: step %0d expects level %0d but model gives %0d",
						idx, s.exp, lv);
				end
				accept = 1'b1;
				tick();
				accept = 1'b0;
				check_bit("vec_valid", vec_valid, lv >= 0);
				if (lv >= 0) begin
					check_level("vec", vec, irq_pkg::level_t'(lv));
					m_rp[lv] = 1'b1;
					m_rz[lv] = 1'b0;
				end
				tick();
				check_bit("vec_valid", vec_valid, 1'b0); // single cycle pulse
			end
			op_rtn: begin
				rtn = 1'b1;
				tick();
				rtn = 1'b0;
				m_rp[top_in_service()] = 1'b0;
			end
			op_bus: begin
				rdt = arg;
				rin = 1'b1;
				tick(); // rin seen at this edge
				n = 0;
				while (dok !== 1'b1 && n <= `DOK_DLY_TICKS + 4) begin
					tick();
					n++;
				end
				if (n != `DOK_DLY_TICKS) begin
					n_errors++;
					$display("Error: dok came %0d cycles after rin instead of %0d",
						n, `DOK_DLY_TICKS);
				end
				m_rz[bus_level(arg)] = 1'b1;
				rin = 1'b0;
				tick();
				check_bit("dok", dok, 1'b0);
			end
		endcase
		check_bit("irq", irq, best_level() >= 0);
		check_word("rz_user", rz_user, user_view());
	endtask

	initial begin
		reset = 1'b1;
		hw_irq = '0;
		data = '0;
		mask_wr = 1'b0;
		rz_wr = 1'b0;
		accept = 1'b0;
		rtn = 1'b0;
		rin = 1'b0;
		rdt = '0;
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		#5 reset = 1'b0;
		check_bit("irq", irq, 1'b0);
		check_bit("vec_valid", vec_valid, 1'b0);
		check_bit("dok", dok, 1'b0);
		check_word("rz_user", rz_user, 16'h0000);
		foreach (tbl[i])
			run_step(i, tbl[i]);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// budget grows with the table, bus steps are the longest
	initial begin
		wait (table_ready);
		#(tbl.size() * (`DOK_DLY_TICKS + 6) * 40);
		$display("Error: watchdog expired before the step table finished");
		$display("Simulation failed");
		$finish;
	end

endmodule
